// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       ?= output_interface_tb
FILELIST  ?= sources.f
SIM_ARGS  ?= +verilator+error+limit+100

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/output_interface_asserts.sv ====
`timescale 1ns/1ps

module output_interface_asserts import out_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input tx_state_e state,
    input byte_sel_e byte_sel,
    input logic      capture,
    input logic      tx_start,
    input logic      tx_busy
);

    int fail_cnt = 0;                          // Failed assertions so far

    // First byte start follows the capture edge after the register wait
    first_start_delay: assert property (@(posedge clk) disable iff (!arst_n)
        capture |-> ##(wait_reg_cycles + 1) $rose(tx_start))
        else begin
            $error("tx_start not %0d cycles after capture", wait_reg_cycles);
            fail_cnt++;
        end

    // Bytes 1 to 3 start a fixed gap after busy drops
    inter_byte_delay: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(tx_busy) && (state == WAIT_BUSY) && (byte_sel != B3)
        |-> ##inter_byte_gap $rose(tx_start))
        else begin
            $error("tx_start not %0d cycles after busy fell", inter_byte_gap);
            fail_cnt++;
        end

    start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else begin
            $error("tx_start issued while transmitter busy");
            fail_cnt++;
        end

    busy_follows_start: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |=> $rose(tx_busy))
        else begin
            $error("tx_busy did not rise after tx_start");
            fail_cnt++;
        end

    // Start, eight data bits and stop
    busy_length: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(tx_busy) |-> ##(10 * clks_per_bit) $fell(tx_busy))
        else begin
            $error("tx_busy not high for ten bit times");
            fail_cnt++;
        end

endmodule

bind tx_ctrl output_interface_asserts asserts_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .state    (state),
    .byte_sel (byte_sel),
    .capture  (capture),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
);

// ==== dv/output_interface_tb.sv ====
`timescale 1ns/1ps

module output_interface_tb import out_pkg::*; ();

    localparam int clk_period   = 20;
    localparam int frame_cycles = 10 * clks_per_bit;
    localparam int entry_cycles = wait_reg_cycles + 4 * (frame_cycles + inter_byte_gap)
                                  + scan_div * num_digits;

    typedef struct packed {
        op_sel_t     op;
        logic [31:0] data;
        logic        show;                  // Display expected lit
        logic        accept;                // Begin should start a transmission
    } entry_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  begin_transmission;
    op_sel_t               op_sel;
    logic [data_w-1:0]     result_data;
    logic                  tx;
    logic                  tx_start;
    logic                  tx_busy;
    logic [7:0]            tx_data;
    logic [6:0]            segments;
    logic [num_digits-1:0] an;

    entry_t      stim_table[$];
    logic [7:0]  rx_q[$];                   // Bytes decoded from tx
    logic [31:0] lfsr;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          assert_fails;

    always #(clk_period / 2) clk = ~clk;

    output_interface output_interface_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .begin_transmission (begin_transmission),
        .op_sel             (op_sel),
        .result_data        (result_data),
        .tx                 (tx),
        .tx_start           (tx_start),
        .tx_busy            (tx_busy),
        .tx_data            (tx_data),
        .segments           (segments),
        .an                 (an)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    // Active low, CA in bit 6
    function automatic logic [3:0] seg_to_digit(input logic [6:0] s);
        case (s)
            7'b000_0001: return 4'd0;
            7'b100_1111: return 4'd1;
            7'b001_0010: return 4'd2;
            7'b000_0110: return 4'd3;
            7'b100_1100: return 4'd4;
            7'b010_0100: return 4'd5;
            7'b010_0000: return 4'd6;
            7'b000_1111: return 4'd7;
            7'b000_0000: return 4'd8;
            7'b000_0100: return 4'd9;
            default:     return 4'hf;
        endcase
    endfunction

    task automatic add_entry(input logic [5:0] op, input logic [31:0] data,
                             input logic show, input logic accept);
        entry_t e;
        e.op     = op_sel_t'(op);
        e.data   = data;
        e.show   = show;
        e.accept = accept;
        stim_table.push_back(e);
    endtask

    // One full scan, every digit lit scan_div times
    task automatic check_display(input entry_t e);
        logic [31:0]           v;
        logic [3:0]            exp_digit [num_digits];
        logic [num_digits-1:0] seen;
        v = (e.data > bcd_max) ? bcd_max : e.data;
        for (int d = 0; d < num_digits; d++) begin
            exp_digit[d] = 4'(v % 10);
            v = v / 10;
        end
        seen = '0;
        for (int c = 0; c < scan_div * num_digits; c++) begin
            @(negedge clk);
            seen = seen | ~an;
            if (!e.show) begin
                check_value(32'(an), 32'hff, "anodes blank");
            end else begin
                check_value($countones(~an), 1, "one anode lit");
                for (int d = 0; d < num_digits; d++) begin
                    if (!an[d]) begin
                        check_value(32'(seg_to_digit(segments)), 32'(exp_digit[d]),
                                    $sformatf("display digit %0d", d));
                    end
                end
            end
        end
        if (e.show) begin
            check_value(32'(seen), 32'hff, "every digit scanned");
        end
    endtask

    task automatic run_entry(input entry_t e);
        int n;
        op_sel             = e.op;
        result_data        = e.data;
        begin_transmission = 1'b1;
        @(negedge clk);
        begin_transmission = 1'b0;
        if (!e.accept) begin
            repeat (4 * wait_reg_cycles) begin
                @(negedge clk);
                check_value(32'({tx_start, tx_busy}), 32'd0, "activity after rejected begin");
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                n = 0;
                while (!tx_start) begin
                    @(negedge clk);
                    n++;
                end
                check_value(n, (b == 0) ? wait_reg_cycles : inter_byte_gap,
                            $sformatf("cycles before tx_start %0d", b));
                check_value(32'(tx_data), 32'(e.data[8*b +: 8]),
                            $sformatf("tx_data at tx_start %0d", b));
                @(negedge clk);
                check_value(32'(tx_busy), 32'd1, "busy after tx_start");
                n = 0;
                if (b == 1) begin
                    begin_transmission = 1'b1;    // Ignored outside IDLE
                    result_data        = ~e.data;
                    @(negedge clk);
                    begin_transmission = 1'b0;
                    n = 1;
                end
                do begin
                    @(negedge clk);
                    n++;
                end while (tx_busy);
                check_value(n, frame_cycles, "busy length");
            end
        end
        check_value(rx_q.size(), e.accept ? 4 : 0, "frame count");
        for (int k = 0; k < rx_q.size() && k < 4; k++) begin
            check_value(32'(rx_q[k]), 32'(e.data[8*k +: 8]), $sformatf("uart byte %0d", k));
        end
        rx_q.delete();
        check_display(e);
    endtask

    // Serial decoder, samples near mid-bit on the falling clock edge
    initial begin
        logic [7:0] rx_byte;
        wait (arst_n);
        forever begin
            @(negedge tx);
            repeat (clks_per_bit / 2) @(negedge clk);
            check_value(32'(tx), 32'd0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                rx_byte[i] = tx;
            end
            repeat (clks_per_bit) @(negedge clk);
            check_value(32'(tx), 32'd1, "stop bit");
            rx_q.push_back(rx_byte);
        end
    end

    initial begin
        #1;
        #(2 * stim_table.size() * entry_cycles * clk_period);
        $display("Timeout: the tests did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        arst_n             = 1'b0;
        begin_transmission = 1'b0;
        op_sel             = op_sel_t'(6'b000100); // Display enabled, only reset keeps it dark
        result_data        = '0;
        lfsr               = 32'h26e8_bf6f;
        add_entry(6'b000100, 32'd12_345_678, 1'b1, 1'b1);   // avg
        add_entry(6'b001000, 32'hffff_ffff, 1'b1, 1'b1);    // euc, saturates
        add_entry(6'b010000, 32'd0, 1'b1, 1'b1);            // man
        add_entry(6'b100000, 32'ha5c3_1e77, 1'b0, 1'b1);    // dot
        add_entry(6'b000010, 32'h0123_4567, 1'b0, 1'b1);    // sum
        add_entry(6'b000001, 32'h8000_0001, 1'b0, 1'b1);    // read
        add_entry(6'b000000, 32'hdead_beef, 1'b0, 1'b0);    // No operation
        add_entry(6'b010000, 32'd100_000_000, 1'b1, 1'b1);  // Just above bcd_max
        add_entry(6'b000100, random_word(), 1'b1, 1'b1);
        add_entry(6'b000010, random_word(), 1'b0, 1'b1);
        add_entry(6'b001000, random_word(), 1'b1, 1'b1);
        add_entry(6'b000001, random_word(), 1'b0, 1'b1);
        repeat (3) @(negedge clk);
        check_value(32'({tx, tx_start, tx_busy}), 32'b100, "line state in reset");
        check_value(32'(an), 32'hff, "anodes in reset");
        arst_n = 1'b1;
        @(negedge clk);
        foreach (stim_table[i]) begin
            run_entry(stim_table[i]);
        end
        assert_fails = output_interface_i.tx_ctrl_i.asserts_i.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rtl/bin2bcd.sv ====
`timescale 1ns/1ps

module bin2bcd import out_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  logic [data_w-1:0] bin,
    output bcd_word_t         bcd
);

    logic                    active;
    logic [dabble_cnt_w-1:0] step;
    logic [data_w-1:0]       bin_sr;
    bcd_word_t               bcd_sr;
    bcd_word_t               bcd_adj;
    bcd_word_t               bcd_next;

    // Add 3 to any digit of five or more, then shift in the next bit
    always_comb begin
        for (int i = 0; i < num_digits; i++) begin
            if (bcd_sr[i] >= 4'd5) begin
                bcd_adj[i] = bcd_sr[i] + 4'd3;
            end else begin
                bcd_adj[i] = bcd_sr[i];
            end
        end
        // Top bit always zero, saturated input stays below eight digits
        bcd_next = {bcd_adj[num_digits-1][2:0], bcd_adj[num_digits-2:0], bin_sr[data_w-1]};
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bin_sr <= (bin > bcd_max) ? bcd_max : bin; // Saturate to eight digits
            bcd_sr <= '0;
        end else if (active) begin
            bin_sr <= bin_sr << 1;
            bcd_sr <= bcd_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            step   <= '0;
            bcd    <= '0;
        end else if (start) begin
            active <= 1'b1;
            step   <= '0;
        end else if (active) begin
            step <= step + 1'b1;
            if (step == dabble_cnt_w'(data_w - 1)) begin
                active <= 1'b0;
                bcd    <= bcd_next;               // Last shift goes straight out
            end
        end
    end

endmodule

// ==== rtl/out_pkg.sv ====
package out_pkg;

    // Datapath width of the coprocessor result
    localparam int data_w = 32;

    // UART timing, kept short for simulation
    localparam int clks_per_bit = 8;                      // Cycles per serial bit
    localparam int baud_cnt_w   = $clog2(clks_per_bit);

    // Transmission sequencing delays
    localparam int wait_reg_cycles = 4;                   // Capture to first byte start
    localparam int inter_byte_gap  = 16;                  // Busy fall to next byte start
    localparam int gap_cnt_w       = $clog2(inter_byte_gap + 1);

    // Display scan and BCD conversion
    localparam int scan_div     = 4;                      // Cycles per lit digit
    localparam int scan_cnt_w   = $clog2(scan_div);
    localparam int num_digits   = 8;
    localparam int digit_idx_w  = $clog2(num_digits);
    localparam int dabble_cnt_w = $clog2(data_w);         // One step per input bit
    localparam logic [data_w-1:0] bcd_max = 32'd99_999_999; // Above this, show all nines

    // One-hot operation select from the control unit, dot is the MSB
    typedef struct packed {
        logic dot;
        logic man;
        logic euc;
        logic avg;
        logic sum;
        logic read;
    } op_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_REG,
        SEND,
        WAIT_BUSY,
        GAP
    } tx_state_e;

    // Result byte on the wire, B0 goes first
    typedef enum logic [1:0] {
        B0,
        B1,
        B2,
        B3
    } byte_sel_e;

    typedef logic [3:0] bcd_digit_t;
    typedef bcd_digit_t [num_digits-1:0] bcd_word_t;      // Digit 0 is least significant

endpackage

// ==== rtl/output_interface.sv ====
`timescale 1ns/1ps

module output_interface import out_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  begin_transmission,
    input  op_sel_t               op_sel,
    input  logic [data_w-1:0]     result_data,
    output logic                  tx,
    output logic                  tx_start,
    output logic                  tx_busy,
    output logic [7:0]            tx_data,
    output logic [6:0]            segments,
    output logic [num_digits-1:0] an
);

    logic              capture;
    logic              bcd_start;
    byte_sel_e         byte_sel;
    logic [data_w-1:0] result_q;
    bcd_word_t         bcd;
    logic              display_en;

    // Only averaged and distance results go to the display
    assign display_en = op_sel.avg | op_sel.euc | op_sel.man;

    tx_ctrl tx_ctrl_i (
        .clk                (clk),
        .arst_n             (arst_n),
        .begin_transmission (begin_transmission),
        .op_sel             (op_sel),
        .tx_busy            (tx_busy),
        .capture            (capture),
        .byte_sel           (byte_sel),
        .tx_start           (tx_start)
    );

    result_buffer result_buffer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .capture     (capture),
        .byte_sel    (byte_sel),
        .result_data (result_data),
        .tx_data     (tx_data),
        .bcd_start   (bcd_start),
        .result_q    (result_q)
    );

    bin2bcd bin2bcd_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (bcd_start),
        .bin    (result_q),
        .bcd    (bcd)
    );

    uart_tx uart_tx_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    seg_driver seg_driver_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (display_en),
        .bcd      (bcd),
        .segments (segments),
        .an       (an)
    );

endmodule

// ==== rtl/result_buffer.sv ====
`timescale 1ns/1ps

module result_buffer import out_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              capture,
    input  byte_sel_e         byte_sel,
    input  logic [data_w-1:0] result_data,
    output logic [7:0]        tx_data,
    output logic              bcd_start,
    output logic [data_w-1:0] result_q
);

    // Held copy, the input may move during a transmission
    always_ff @(posedge clk) begin
        if (capture) begin
            result_q <= result_data;
        end
    end

    // Converter starts once the register holds the new value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bcd_start <= 1'b0;
        end else begin
            bcd_start <= capture;
        end
    end

    always_comb begin
        case (byte_sel)
            B0:      tx_data = result_q[7:0];     // LSB first on the wire
            B1:      tx_data = result_q[15:8];
            B2:      tx_data = result_q[23:16];
            B3:      tx_data = result_q[31:24];
            default: tx_data = result_q[7:0];
        endcase
    end

endmodule

// ==== rtl/seg_driver.sv ====
`timescale 1ns/1ps

module seg_driver import out_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  bcd_word_t             bcd,
    output logic [6:0]            segments,
    output logic [num_digits-1:0] an
);

    logic [scan_cnt_w-1:0]  scan_cnt;
    logic [digit_idx_w-1:0] digit_idx;
    bcd_digit_t             digit;
    logic [6:0]             seg_dec;

    assign digit = bcd[digit_idx];

    // Active low, bit 6 is CA down to bit 0 at CG
    always_comb begin
        case (digit)
            4'd0:    seg_dec = 7'b000_0001;
            4'd1:    seg_dec = 7'b100_1111;
            4'd2:    seg_dec = 7'b001_0010;
            4'd3:    seg_dec = 7'b000_0110;
            4'd4:    seg_dec = 7'b100_1100;
            4'd5:    seg_dec = 7'b010_0100;
            4'd6:    seg_dec = 7'b010_0000;
            4'd7:    seg_dec = 7'b000_1111;
            4'd8:    seg_dec = 7'b000_0000;
            4'd9:    seg_dec = 7'b000_0100;
            default: seg_dec = 7'b111_1111;    // Not a BCD digit, dark
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == scan_cnt_w'(scan_div - 1)) begin
            scan_cnt <= '0;
            if (digit_idx == digit_idx_w'(num_digits - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Registered so anode and segments switch on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            an       <= '1;
            segments <= '1;
        end else if (enable) begin
            an       <= ~(num_digits'(1) << digit_idx);
            segments <= seg_dec;
        end else begin
            an       <= '1;                    // Blank display
            segments <= '1;
        end
    end

endmodule

// ==== rtl/tx_ctrl.sv ====
`timescale 1ns/1ps

module tx_ctrl import out_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      begin_transmission,
    input  op_sel_t   op_sel,
    input  logic      tx_busy,
    output logic      capture,
    output byte_sel_e byte_sel,
    output logic      tx_start
);

    tx_state_e            state;
    logic [gap_cnt_w-1:0] cnt;
    logic                 busy_q;
    logic                 busy_fall;

    // Accept only from IDLE with some operation selected
    assign capture   = (state == IDLE) && begin_transmission && (|op_sel);
    assign tx_start  = (state == SEND);
    assign busy_fall = busy_q && !tx_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= tx_busy;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            cnt      <= '0;
            byte_sel <= B0;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state    <= WAIT_REG;
                        cnt      <= gap_cnt_w'(wait_reg_cycles - 1);
                        byte_sel <= B0;
                    end
                end
                WAIT_REG: begin
                    if (cnt == '0) begin
                        state <= SEND;                // Start lands wait_reg_cycles after capture
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                SEND: begin
                    state <= WAIT_BUSY;               // Single-cycle start strobe
                end
                WAIT_BUSY: begin
                    if (busy_fall) begin
                        if (byte_sel == B3) begin
                            state <= IDLE;            // All four bytes out
                        end else begin
                            state    <= GAP;
                            byte_sel <= byte_sel_e'(byte_sel + 1'b1);
                            // Fall was seen one cycle late, so two less
                            cnt      <= gap_cnt_w'(inter_byte_gap - 2);
                        end
                    end
                end
                GAP: begin
                    if (cnt == '0) begin
                        state <= SEND;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import out_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    logic [9:0]            frame;              // Stop, data, start; bit 0 on the line
    logic [baud_cnt_w-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic                  bit_end;

    assign bit_end = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));
    assign tx      = frame[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame    <= '1;                    // Line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else begin
            if (bit_end) begin
                baud_cnt <= '0;
                frame    <= {1'b1, frame[9:1]}; // Shift in idle level
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;           // Stop bit done, ten bit times total
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== sources.f ====
rtl/out_pkg.sv
rtl/tx_ctrl.sv
rtl/result_buffer.sv
rtl/bin2bcd.sv
rtl/uart_tx.sv
rtl/seg_driver.sv
rtl/output_interface.sv
dv/output_interface_asserts.sv
dv/output_interface_tb.sv
